// File: design/idctMacros.svh
`ifndef IDCT_MACROS_SVH
`define IDCT_MACROS_SVH

// Block geometry
`define BLOCK_DIM 8
`define BLOCK_WORDS 64
`define LANES 4

// Data widths
`define SAMPLE_W 16
`define WORD_W 32
`define PIXEL_W 8

// Cosine table is Q12
`define COEF_FRAC 12

// Arithmetic right shifts after each matrix pass
`define PASS1_SHIFT 8
`define PASS2_SHIFT 16

`endif

// File: design/idctPkg.sv
`include "idctMacros.svh"

package idctPkg;

	// Controller states
	typedef enum logic [2:0] {
		stIdle,
		stLoad,
		stPass1,
		stPass2,
		stDrain
	} idctState_t;

	// Pass one broadcasts a sample against a coefficient row,
	// pass two broadcasts a coefficient against a row of T
	typedef enum logic [1:0] {
		opIdle,
		opPass1,
		opPass2
	} macOp_t;

	typedef logic signed [`WORD_W-1:0] word_t;
	typedef logic [`PIXEL_W-1:0] pixel_t;

endpackage

// File: design/idctOperandIf.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

interface idctOperandIf;
	import idctPkg::*;

	word_t [`LANES-1:0] sampleLanes;
	word_t [`LANES-1:0] coefLanes;

	// Request control, in step with the read addresses
	logic opValid;
	logic opFirst;
	logic opLast;
	macOp_t op;

	// Same control one cycle later, in step with the read data
	logic opValidQ;
	logic opFirstQ;
	logic opLastQ;
	macOp_t opQ;

	modport ctrlSide (output opValid, opFirst, opLast, op);
	modport bufferSide (input opValid, opFirst, opLast, op,
		output sampleLanes, opValidQ, opFirstQ, opLastQ, opQ);
	modport romSide (input op, output coefLanes);
	modport macSide (input sampleLanes, coefLanes, opValidQ, opFirstQ, opLastQ, opQ);

endinterface

// File: design/blockBuffer.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module blockBuffer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic loadWrite,
	input logic signed [`SAMPLE_W-1:0] inData,
	input logic [$clog2(`BLOCK_DIM)-1:0] rdRow,
	input logic [$clog2(`BLOCK_DIM)-1:0] rdCol,
	input logic [$clog2(`BLOCK_DIM/`LANES)-1:0] rdGroup,
	input logic resValid,
	input idctPkg::word_t [`LANES-1:0] results,
	input logic [$clog2(`BLOCK_DIM)-1:0] resRow,
	input logic [$clog2(`BLOCK_DIM/`LANES)-1:0] resGroup,
	output idctPkg::pixel_t outData,
	idctOperandIf.bufferSide bufIf
);
	import idctPkg::*;

	localparam int LANE_W = $clog2(`LANES);

	// Bank A holds the samples and later the pixels, bank B holds T
	word_t bankA [`BLOCK_WORDS];
	word_t bankB [`BLOCK_WORDS];

	always_ff @(posedge CLOCK_50_I) begin
		if (loadWrite) begin
			bankA[{rdRow, rdCol}] <= inData;
		end
		// A result batch is four adjacent words of one row
		if (resValid) begin
			for (int j = 0; j < `LANES; j++) begin
				if (bufIf.op == opPass1) begin
					bankB[{resRow, resGroup, LANE_W'(j)}] <= results[j];
				end else begin
					bankA[{resRow, resGroup, LANE_W'(j)}] <= results[j];
				end
			end
		end
	end

	// Pass one broadcasts S'[row][col], pass two reads T[col][group lanes]
	always_ff @(posedge CLOCK_50_I) begin
		for (int j = 0; j < `LANES; j++) begin
			if (bufIf.op == opPass1) begin
				bufIf.sampleLanes[j] <= bankA[{rdRow, rdCol}];
			end else begin
				bufIf.sampleLanes[j] <= bankB[{rdCol, rdGroup, LANE_W'(j)}];
			end
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			bufIf.opValidQ <= 1'b0;
			bufIf.opFirstQ <= 1'b0;
			bufIf.opLastQ <= 1'b0;
			bufIf.opQ <= opIdle;
		end else begin
			bufIf.opValidQ <= bufIf.opValid;
			bufIf.opFirstQ <= bufIf.opFirst;
			bufIf.opLastQ <= bufIf.opLast;
			bufIf.opQ <= bufIf.op;
		end
	end

	// Drain reads the clipped pixels straight from bank A
	assign outData = bankA[{rdRow, rdCol}][`PIXEL_W-1:0];

endmodule

// File: design/cosineRom.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module cosineRom (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic [$clog2(`BLOCK_DIM)-1:0] rdRow,
	input logic [$clog2(`BLOCK_DIM)-1:0] rdCol,
	input logic [$clog2(`BLOCK_DIM/`LANES)-1:0] rdGroup,
	idctOperandIf.romSide rom
);
	import idctPkg::*;

	localparam int LANE_W = $clog2(`LANES);

	// C[k][n] lives at k*8+n
	word_t cosTable [`BLOCK_WORDS];

	// Half of cos(m*pi/16) in Q12
	function automatic word_t halfCos(input int m);
		case (m)
			0: return word_t'(1 << (`COEF_FRAC - 1));
			1: return word_t'(2009);
			2: return word_t'(1892);
			3: return word_t'(1703);
			4: return word_t'(1448);
			5: return word_t'(1138);
			6: return word_t'(784);
			7: return word_t'(400);
			default: return '0;
		endcase
	endfunction

	function automatic word_t cosEntry(input int k, input int n);
		int m;
		// DC column uses sqrt(1/8)
		if (n == 0) begin
			return word_t'(1448);
		end
		m = ((2 * k + 1) * n) % 32;
		if (m > 16) begin
			m = 32 - m;
		end
		if (m > 8) begin
			return -halfCos(16 - m);
		end
		return halfCos(m);
	endfunction

	always_comb begin
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			cosTable[i] = cosEntry(i / `BLOCK_DIM, i % `BLOCK_DIM);
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			rom.coefLanes <= '0;
		end else begin
			for (int j = 0; j < `LANES; j++) begin
				case (rom.op)
					opPass1: rom.coefLanes[j] <= cosTable[{rdCol, rdGroup, LANE_W'(j)}];
					// Transposed lookup, one entry to every lane
					opPass2: rom.coefLanes[j] <= cosTable[{rdCol, rdRow}];
					default: rom.coefLanes[j] <= '0;
				endcase
			end
		end
	end

endmodule

// File: design/macArray.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module macArray (
	input logic CLOCK_50_I,
	input logic Resetn,
	idctOperandIf.macSide mac,
	output logic resValid,
	output idctPkg::word_t [`LANES-1:0] results
);
	import idctPkg::*;

	localparam int ACC_W = 2 * `WORD_W;
	localparam int PIX_MAX = (1 << `PIXEL_W) - 1;

	logic signed [ACC_W-1:0] prod [`LANES];
	logic signed [ACC_W-1:0] acc [`LANES];
	logic signed [ACC_W-1:0] shifted [`LANES];
	logic prodValid;
	logic prodFirst;
	logic prodLast;
	macOp_t prodOp;
	macOp_t accOp;

	// Product stage
	always_ff @(posedge CLOCK_50_I) begin
		for (int j = 0; j < `LANES; j++) begin
			prod[j] <= $signed(mac.sampleLanes[j]) * $signed(mac.coefLanes[j]);
		end
	end

	// Accumulate stage, a new batch starts on its first product
	always_ff @(posedge CLOCK_50_I) begin
		for (int j = 0; j < `LANES; j++) begin
			if (prodValid) begin
				acc[j] <= prodFirst ? prod[j] : acc[j] + prod[j];
			end
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			prodValid <= 1'b0;
			prodFirst <= 1'b0;
			prodLast <= 1'b0;
			prodOp <= opIdle;
			accOp <= opIdle;
			resValid <= 1'b0;
		end else begin
			prodValid <= mac.opValidQ;
			prodFirst <= mac.opFirstQ;
			prodLast <= mac.opLastQ;
			prodOp <= mac.opQ;
			resValid <= prodValid && prodLast;
			if (prodValid) begin
				accOp <= prodOp;
			end
		end
	end

	// Scale the finished sums, pass two also clips to a pixel
	always_comb begin
		for (int j = 0; j < `LANES; j++) begin
			if (accOp == opPass2) begin
				shifted[j] = acc[j] >>> `PASS2_SHIFT;
				if (shifted[j] < 0) begin
					results[j] = '0;
				end else if (shifted[j] > PIX_MAX) begin
					results[j] = word_t'(PIX_MAX);
				end else begin
					results[j] = word_t'(shifted[j]);
				end
			end else begin
				shifted[j] = acc[j] >>> `PASS1_SHIFT;
				results[j] = word_t'(shifted[j]);
			end
		end
	end

endmodule

// File: design/idctController.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module idctController (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic inValid,
	input logic outReady,
	output logic inReady,
	output logic outValid,
	output logic done,
	output logic loadWrite,
	output logic [$clog2(`BLOCK_DIM)-1:0] rdRow,
	output logic [$clog2(`BLOCK_DIM)-1:0] rdCol,
	output logic [$clog2(`BLOCK_DIM/`LANES)-1:0] rdGroup,
	output logic [$clog2(`BLOCK_DIM)-1:0] resRow,
	output logic [$clog2(`BLOCK_DIM/`LANES)-1:0] resGroup,
	idctOperandIf.ctrlSide ctrl
);
	import idctPkg::*;

	localparam int IDX_W = $clog2(`BLOCK_DIM);
	localparam int GRP_W = $clog2(`BLOCK_DIM / `LANES);
	// Request to result write: buffer read, product, accumulate
	localparam int RES_LAT = 3;

	idctState_t state;
	logic [$clog2(`BLOCK_WORDS)-1:0] streamIdx;
	logic [IDX_W-1:0] rowIdx;
	logic [GRP_W-1:0] groupIdx;
	logic [IDX_W-1:0] prodIdx;
	logic [$clog2(RES_LAT)-1:0] flushCount;
	logic issuing;
	logic inPass;
	logic reqValid;
	logic [IDX_W-1:0] rowPipe [RES_LAT];
	logic [GRP_W-1:0] groupPipe [RES_LAT];

	assign inPass = (state == stPass1) || (state == stPass2);
	assign inReady = (state == stLoad);
	assign outValid = (state == stDrain);
	assign loadWrite = inValid && inReady;

	assign reqValid = inPass && issuing;
	assign ctrl.opValid = reqValid;
	assign ctrl.opFirst = reqValid && (prodIdx == '0);
	assign ctrl.opLast = reqValid && (&prodIdx);
	assign ctrl.op = (state == stPass1) ? opPass1 : (state == stPass2) ? opPass2 : opIdle;

	// Stream index addresses the block in load and drain
	assign rdRow = inPass ? rowIdx : streamIdx[IDX_W +: IDX_W];
	assign rdCol = inPass ? prodIdx : streamIdx[IDX_W-1:0];
	assign rdGroup = inPass ? groupIdx : '0;

	// Row and group follow each batch through the MAC pipeline
	always_ff @(posedge CLOCK_50_I) begin
		rowPipe[0] <= rowIdx;
		groupPipe[0] <= groupIdx;
		for (int i = 1; i < RES_LAT; i++) begin
			rowPipe[i] <= rowPipe[i-1];
			groupPipe[i] <= groupPipe[i-1];
		end
	end
	assign resRow = rowPipe[RES_LAT-1];
	assign resGroup = groupPipe[RES_LAT-1];

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			state <= stIdle;
			streamIdx <= '0;
			{rowIdx, groupIdx, prodIdx} <= '0;
			flushCount <= '0;
			issuing <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				stIdle: begin
					if (start) begin
						streamIdx <= '0;
						state <= stLoad;
					end
				end
				stLoad: begin
					if (loadWrite) begin
						streamIdx <= streamIdx + 1'b1;
						if (&streamIdx) begin
							{rowIdx, groupIdx, prodIdx} <= '0;
							issuing <= 1'b1;
							state <= stPass1;
						end
					end
				end
				stPass1, stPass2: begin
					// Products innermost, then lane groups, then rows
					if (issuing) begin
						{rowIdx, groupIdx, prodIdx} <= {rowIdx, groupIdx, prodIdx} + 1'b1;
						if ((&rowIdx) && (&groupIdx) && (&prodIdx)) begin
							issuing <= 1'b0;
						end
					end else begin
						flushCount <= flushCount + 1'b1;
						if (flushCount == RES_LAT - 1) begin
							flushCount <= '0;
							issuing <= (state == stPass1);
							state <= (state == stPass1) ? stPass2 : stDrain;
						end
					end
				end
				stDrain: begin
					if (outReady) begin
						streamIdx <= streamIdx + 1'b1;
						if (&streamIdx) begin
							done <= 1'b1;
							state <= stIdle;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// File: design/idctBlock.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module idctBlock (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic inValid,
	input logic signed [`SAMPLE_W-1:0] inData,
	input logic outReady,
	output logic inReady,
	output logic outValid,
	output idctPkg::pixel_t outData,
	output logic done
);
	import idctPkg::*;

	logic loadWrite;
	logic [$clog2(`BLOCK_DIM)-1:0] rdRow;
	logic [$clog2(`BLOCK_DIM)-1:0] rdCol;
	logic [$clog2(`BLOCK_DIM/`LANES)-1:0] rdGroup;
	logic [$clog2(`BLOCK_DIM)-1:0] resRow;
	logic [$clog2(`BLOCK_DIM/`LANES)-1:0] resGroup;
	logic resValid;
	word_t [`LANES-1:0] results;

	idctOperandIf opBus ();

	idctController ctrlUnit (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.inValid(inValid),
		.outReady(outReady),
		.inReady(inReady),
		.outValid(outValid),
		.done(done),
		.loadWrite(loadWrite),
		.rdRow(rdRow),
		.rdCol(rdCol),
		.rdGroup(rdGroup),
		.resRow(resRow),
		.resGroup(resGroup),
		.ctrl(opBus)
	);

	// Buffer and ROM answer the same request side by side
	blockBuffer bufferUnit (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.loadWrite(loadWrite),
		.inData(inData),
		.rdRow(rdRow),
		.rdCol(rdCol),
		.rdGroup(rdGroup),
		.resValid(resValid),
		.results(results),
		.resRow(resRow),
		.resGroup(resGroup),
		.outData(outData),
		.bufIf(opBus)
	);

	cosineRom romUnit (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.rdRow(rdRow),
		.rdCol(rdCol),
		.rdGroup(rdGroup),
		.rom(opBus)
	);

	macArray macUnit (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.mac(opBus),
		.resValid(resValid),
		.results(results)
	);

endmodule

// File: verification/idctBlock_properties.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module handshakeChecker (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic [`PIXEL_W-1:0] outData,
	input logic done
);

	int failCount = 0;
	logic started;
	logic [$clog2(`BLOCK_WORDS)-1:0] pixCount;

	// Pixel count wraps once per block
	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			started <= 1'b0;
			pixCount <= '0;
		end else begin
			if (start) begin
				started <= 1'b1;
			end
			if (outValid && outReady) begin
				pixCount <= pixCount + 1'b1;
			end
		end
	end

	quietBeforeStart: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!started |-> (!inReady && !outValid && !done))
	else begin
		failCount++;
		$error("inReady, outValid or done went high before the first start");
	end

	holdWhileStalled: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		(outValid && !outReady) |=> (outValid && $stable(outData)))
	else begin
		failCount++;
		$error("outData or outValid changed while the output stream was stalled");
	end

	doneAfterLastPixel: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		(outValid && outReady && (&pixCount)) |=> done)
	else begin
		failCount++;
		$error("done did not follow the 64th accepted pixel");
	end

	doneOnlyAfterLastPixel: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		done |-> $past(outValid && outReady && (&pixCount)))
	else begin
		failCount++;
		$error("done pulsed without a 64th accepted pixel");
	end

	loadOnlyAfterStart: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		$rose(inReady) |-> $past(start))
	else begin
		failCount++;
		$error("inReady rose outside the cycle after start");
	end

endmodule

bind idctBlock handshakeChecker handshakeChk (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.start(start),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.outData(outData),
	.done(done)
);

// File: verification/idctBlockTb.sv
`timescale 1ns/10ps
`include "idctMacros.svh"

module idctBlockTb;

	localparam int NUM_BLOCKS = 8;
	localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 600 + 100;
	localparam real PI = 3.14159265358979;

	logic CLOCK_50_I = 1'b0;
	logic Resetn;
	logic start;
	logic inValid;
	logic signed [`SAMPLE_W-1:0] inData;
	logic outReady;
	logic inReady;
	logic outValid;
	logic [`PIXEL_W-1:0] outData;
	logic done;

	integer seed = 32'h5c7ef447;
	int valueErrors = 0;
	int flowErrors = 0;
	int cosTab [`BLOCK_WORDS];
	int coefs [`BLOCK_WORDS];
	int expPix [`BLOCK_WORDS];

	idctBlock dut_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.inValid(inValid),
		.inData(inData),
		.outReady(outReady),
		.inReady(inReady),
		.outValid(outValid),
		.outData(outData),
		.done(done)
	);

	always #10 CLOCK_50_I = ~CLOCK_50_I;

	function automatic int roundToInt(input real x);
		if (x < 0.0) begin
			return -$rtoi(0.5 - x);
		end
		return $rtoi(x + 0.5);
	endfunction

	// C[k][n] = round(4096 a(n) cos((2k+1) n pi / 16))
	function automatic int cosineEntry(input int k, input int n);
		real scale;
		real angle;
		scale = (n == 0) ? $sqrt(1.0 / 8.0) : $sqrt(2.0 / 8.0);
		angle = (2 * k + 1) * n * PI / 16.0;
		return roundToInt((1 << `COEF_FRAC) * scale * $cos(angle));
	endfunction

	// T = S' * C, then S = C^T * T, each pass shifted, then clipped to a pixel
	task automatic computeExpected();
		longint sum;
		longint tMat [`BLOCK_WORDS];
		for (int r = 0; r < `BLOCK_DIM; r++) begin
			for (int n = 0; n < `BLOCK_DIM; n++) begin
				sum = 0;
				for (int k = 0; k < `BLOCK_DIM; k++) begin
					sum += longint'(coefs[r * `BLOCK_DIM + k]) * cosTab[k * `BLOCK_DIM + n];
				end
				tMat[r * `BLOCK_DIM + n] = sum >>> `PASS1_SHIFT;
			end
		end
		for (int i = 0; i < `BLOCK_DIM; i++) begin
			for (int n = 0; n < `BLOCK_DIM; n++) begin
				sum = 0;
				for (int m = 0; m < `BLOCK_DIM; m++) begin
					sum += longint'(cosTab[m * `BLOCK_DIM + i]) * tMat[m * `BLOCK_DIM + n];
				end
				sum = sum >>> `PASS2_SHIFT;
				expPix[i * `BLOCK_DIM + n] = (sum < 0) ? 0 : (sum > 255) ? 255 : int'(sum);
			end
		end
	endtask

	task automatic fillDcBlock(input int dc);
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			coefs[i] = 0;
		end
		coefs[0] = dc;
	endtask

	task automatic fillRandomBlock();
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			coefs[i] = $random(seed) % 513;
		end
	endtask

	// Feeds one block with gaps in inValid and drains it with a throttled outReady
	task automatic runBlock();
		int sampleCount;
		int pixCount;
		sampleCount = 0;
		pixCount = 0;
		computeExpected();
		@(posedge CLOCK_50_I);
		start <= 1'b1;
		@(posedge CLOCK_50_I);
		start <= 1'b0;
		while (pixCount < `BLOCK_WORDS) begin
			@(posedge CLOCK_50_I);
			if (inValid && inReady) begin
				sampleCount++;
			end
			if (outValid && outReady) begin
				assert (int'(outData) == expPix[pixCount]) else begin
					$display("[ERROR] %0t outData expected %0d actual %0d",
						$time, expPix[pixCount], outData);
					valueErrors++;
				end
				pixCount++;
			end
			inValid <= (sampleCount < `BLOCK_WORDS) && (($random(seed) % 4) != 0);
			inData <= `SAMPLE_W'(coefs[sampleCount % `BLOCK_WORDS]);
			outReady <= (($random(seed) % 2) == 0);
		end
		@(posedge CLOCK_50_I);
		assert (done && !outValid) else begin
			$display("Block end wrong: no done pulse after the last pixel, or output still valid");
			flowErrors++;
		end
		inValid <= 1'b0;
		outReady <= 1'b0;
	endtask

	initial begin
		int propErrors;
		Resetn = 1'b0;
		start = 1'b0;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b0;
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			cosTab[i] = cosineEntry(i / `BLOCK_DIM, i % `BLOCK_DIM);
		end
		repeat (4) @(posedge CLOCK_50_I);
		Resetn <= 1'b1;
		// Some idle cycles so the quiet-before-start check sees activity
		repeat (5) @(posedge CLOCK_50_I);
		fillDcBlock(0);
		runBlock();
		fillDcBlock(1000);
		runBlock();
		// Saturation at both ends of the pixel range
		fillDcBlock(32767);
		runBlock();
		fillDcBlock(-32768);
		runBlock();
		for (int b = 0; b < NUM_BLOCKS - 4; b++) begin
			fillRandomBlock();
			runBlock();
		end
		propErrors = dut_i.handshakeChk.failCount;
		$display("Error counts: %0d pixel value, %0d block flow, %0d handshake property",
			valueErrors, flowErrors, propErrors);
		if (valueErrors + flowErrors + propErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50_I);
		$display("Timeout: the blocks did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: idctBlock.f
+incdir+design
design/idctPkg.sv
design/idctOperandIf.sv
design/blockBuffer.sv
design/cosineRom.sv
design/macArray.sv
design/idctController.sv
design/idctBlock.sv
verification/idctBlock_properties.sv
verification/idctBlockTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= idctBlockTb
FILE_LIST ?= idctBlock.f
BUILD_DIR ?= obj_dir
SIM_BIN ?= $(BUILD_DIR)/$(TOP)
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= >>> PASS

SOURCES := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
